//--- hw/rv32Decode_settings.svh
// RV32 decode widths
`ifndef RV32DECODE_SETTINGS_SVH
`define RV32DECODE_SETTINGS_SVH

// Instruction word and immediate width
`define XLEN 32

// Register file address width
`define REG_ADDR_W 5

// Exact ALU operation code width
`define ALU_CTRL_W 5

// ALU operation class width
`define ALU_OP_W 3

`endif

//--- hw/decodePkg.sv
// Decode stage types
`default_nettype none

`include "rv32Decode_settings.svh"

package decodePkg;

    // RV32 major opcodes, low two bits always 11
    typedef enum logic [6:0]
    {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcodeE;

    // ALU class, tells execute how to pick its operands
    typedef enum logic [`ALU_OP_W-1:0]
    {
        AOP_MEMADDR = 3'b000,
        AOP_BRANCH  = 3'b001,
        AOP_ARITH   = 3'b010,
        AOP_JUMP    = 3'b011,
        AOP_UPPER   = 3'b100,
        AOP_PCREL   = 3'b101,
        AOP_JUMPREG = 3'b111
    } aluOpE;

    // Exact ALU operation
    // Code 5 unused
    typedef enum logic [`ALU_CTRL_W-1:0]
    {
        ALU_AND    = 5'd0,
        ALU_OR     = 5'd1,
        ALU_ADD    = 5'd2,
        ALU_XOR    = 5'd3,
        ALU_SUB    = 5'd4,
        ALU_SLL    = 5'd6,
        ALU_SRL    = 5'd7,
        ALU_SRA    = 5'd8,
        ALU_SLT    = 5'd9,
        ALU_SLTU   = 5'd10,
        ALU_MUL    = 5'd11,
        ALU_MULH   = 5'd12,
        ALU_MULHSU = 5'd13,
        ALU_MULHU  = 5'd14,
        ALU_DIV    = 5'd15,
        ALU_DIVU   = 5'd16,
        ALU_REM    = 5'd17,
        ALU_REMU   = 5'd18
    } aluCtrlE;

    // Raw register fields of the held word
    typedef struct packed
    {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [2:0]             func3;
    } instrFieldsT;

    // Datapath controls
    typedef struct packed
    {
        logic    memWrite;
        logic    memRead;
        logic    regWrite;
        logic    aluSrc;
        aluOpE   aluOp;
        aluCtrlE aluCtrl;
        logic    branch;
        logic    memToReg;
    } ctrlT;

    // Everything the stage hands to execute
    typedef struct packed
    {
        instrFieldsT      fields;
        logic [`XLEN-1:0] imm;
        ctrlT             ctrl;
    } decodeOutT;

endpackage

`default_nettype wire

//--- hw/instrLatch.sv
// Instruction handshake latch
`default_nettype none

`include "rv32Decode_settings.svh"

module instrLatch
(
    input  logic             clk,
    input  logic             rst,
    input  logic             req,
    input  logic [`XLEN-1:0] instr,
    output logic             ack,
    output logic [`XLEN-1:0] held
);

    // IDLE waits for req, HOLD keeps ack up until req drops
    typedef enum logic
    {
        IDLE = 1'b0,
        HOLD = 1'b1
    } latchStateE;

    latchStateE state;
    logic       capture;

    // Take the word only on the IDLE to HOLD move
    assign capture = (state == IDLE) && req;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (req)
                        state <= HOLD;
                end
                HOLD:
                begin
                    // Four-phase return to zero
                    if (!req)
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Zero word decodes as NOP after reset
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            held <= '0;
        else if (capture)
            held <= instr;
    end

    assign ack = (state == HOLD);

    // Ack only answers a request seen on the previous edge
    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req));

    // Decoded outputs must not move under a raised ack
    heldStable: assert property (@(posedge clk) disable iff (rst)
        (ack && $past(ack)) |-> $stable(held));

endmodule

`default_nettype wire

//--- hw/immGen.sv
// Immediate generator
`default_nettype none

`include "rv32Decode_settings.svh"

module immGen
    import decodePkg::*;
(
    input  logic [`XLEN-1:0] held,
    output logic [`XLEN-1:0] imm
);

    opcodeE opcode;
    logic   sign;

    assign opcode = opcodeE'(held[6:0]);

    // Every format extends from bit 31
    assign sign = held[31];

    always_comb
    begin
        case (opcode)
            // I-type, 12 bits straight from the top
            OPC_LOAD, OPC_OPIMM, OPC_JALR:
                imm = {{(`XLEN-12){sign}}, held[31:20]};
            // S-type, offset split around rs2/rs1
            OPC_STORE:
                imm = {{(`XLEN-12){sign}}, held[31:25], held[11:7]};
            // B-type, halfword aligned
            OPC_BRANCH:
                imm = {{(`XLEN-13){sign}}, held[31], held[7], held[30:25],
                       held[11:8], 1'b0};
            // U-type, upper 20 bits
            OPC_LUI, OPC_AUIPC:
                imm = {held[31:12], 12'b0};
            // J-type, halfword aligned
            OPC_JAL:
                imm = {{(`XLEN-21){sign}}, held[31], held[19:12], held[20],
                       held[30:21], 1'b0};
            // NOP and anything unknown
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/aluCtrlDecode.sv
// ALU control decoder
`default_nettype none

`include "rv32Decode_settings.svh"

module aluCtrlDecode
    import decodePkg::*;
(
    input  logic [`XLEN-1:0] held,
    output aluCtrlE          aluCtrl
);

    opcodeE     opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    logic       isMulDiv;
    logic       altBit;

    assign opcode = opcodeE'(held[6:0]);
    assign func3  = held[14:12];
    assign func7  = held[31:25];

    // M extension shares the OP opcode
    assign isMulDiv = (opcode == OPC_OP) && (func7 == 7'b0000001);

    // Bit 30 picks SUB and SRA
    assign altBit = func7[5];

    always_comb
    begin
        aluCtrl = ALU_ADD;
        if (isMulDiv)
        begin
            case (func3)
                3'b000: aluCtrl = ALU_MUL;
                3'b001: aluCtrl = ALU_MULH;
                3'b010: aluCtrl = ALU_MULHSU;
                3'b011: aluCtrl = ALU_MULHU;
                3'b100: aluCtrl = ALU_DIV;
                3'b101: aluCtrl = ALU_DIVU;
                3'b110: aluCtrl = ALU_REM;
                default: aluCtrl = ALU_REMU;
            endcase
        end
        else if ((opcode == OPC_OP) || (opcode == OPC_OPIMM))
        begin
            case (func3)
                // ADDI has no SUB form, its bit 30 is immediate
                3'b000: aluCtrl = (opcode == OPC_OP && altBit) ? ALU_SUB : ALU_ADD;
                3'b001: aluCtrl = ALU_SLL;
                3'b010: aluCtrl = ALU_SLT;
                3'b011: aluCtrl = ALU_SLTU;
                3'b100: aluCtrl = ALU_XOR;
                // Shift right, logical or arithmetic
                3'b101: aluCtrl = altBit ? ALU_SRA : ALU_SRL;
                3'b110: aluCtrl = ALU_OR;
                default: aluCtrl = ALU_AND;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/ctrlDecode.sv
// Opcode control decoder
`default_nettype none

`include "rv32Decode_settings.svh"

module ctrlDecode
    import decodePkg::*;
(
    input  logic [`XLEN-1:0] held,
    input  aluCtrlE          aluCtrl,
    output ctrlT             ctrl
);

    opcodeE opcode;

    assign opcode = opcodeE'(held[6:0]);

    always_comb
    begin
        // NOP unless the opcode says otherwise
        ctrl.memWrite = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = AOP_ARITH;
        ctrl.aluCtrl  = ALU_ADD;
        ctrl.branch   = 1'b0;
        ctrl.memToReg = 1'b0;
        case (opcode)
            OPC_LUI:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = AOP_UPPER;
            end
            // pc plus upper immediate
            OPC_AUIPC:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = AOP_PCREL;
            end
            // Jumps write the link address
            OPC_JAL:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.branch   = 1'b1;
                ctrl.aluOp    = AOP_JUMP;
            end
            OPC_JALR:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.branch   = 1'b1;
                ctrl.aluOp    = AOP_JUMPREG;
            end
            // Compare via subtraction of two registers
            OPC_BRANCH:
            begin
                ctrl.aluSrc  = 1'b0;
                ctrl.branch  = 1'b1;
                ctrl.aluOp   = AOP_BRANCH;
                ctrl.aluCtrl = ALU_SUB;
            end
            // Address is rs1 plus offset
            OPC_LOAD:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluOp    = AOP_MEMADDR;
            end
            OPC_STORE:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = AOP_MEMADDR;
            end
            // func3/func7 decide the operation
            OPC_OPIMM:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = aluCtrl;
            end
            OPC_OP:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b0;
                ctrl.aluCtrl  = aluCtrl;
            end
            default:
            begin
            end
        endcase
    end

    // Memory port does one access per instruction
    always_comb
    begin
        memExclusive: assert final (!(ctrl.memRead && ctrl.memWrite));
        storeNoWb: assert final (!(ctrl.memWrite && ctrl.regWrite));
    end

endmodule

`default_nettype wire

//--- hw/decodeStage.sv
// RV32IM decode stage top
`default_nettype none

`include "rv32Decode_settings.svh"

module decodeStage
    import decodePkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             req,
    input  logic [`XLEN-1:0] instr,
    output logic             ack,
    output decodeOutT        decoded
);

    logic [`XLEN-1:0] heldWord;
    logic [`XLEN-1:0] immVal;
    aluCtrlE          aluCtrlVal;
    ctrlT             ctrlVal;

    // Fetch handshake and word register
    instrLatch uLatch
    (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .instr (instr),
        .ack   (ack),
        .held  (heldWord)
    );

    immGen uImm
    (
        .held (heldWord),
        .imm  (immVal)
    );

    aluCtrlDecode uAluCtrl
    (
        .held    (heldWord),
        .aluCtrl (aluCtrlVal)
    );

    ctrlDecode uCtrl
    (
        .held    (heldWord),
        .aluCtrl (aluCtrlVal),
        .ctrl    (ctrlVal)
    );

    // Register fields are plain slices
    assign decoded.fields.rd    = heldWord[11:7];
    assign decoded.fields.rs1   = heldWord[19:15];
    assign decoded.fields.rs2   = heldWord[24:20];
    assign decoded.fields.func3 = heldWord[14:12];
    assign decoded.imm          = immVal;
    assign decoded.ctrl         = ctrlVal;

endmodule

`default_nettype wire

//--- verif/decodeChecker.sv
// Decode output checker
`default_nettype none

`include "rv32Decode_settings.svh"

module decodeChecker
    import decodePkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  logic      ack,
    input  decodeOutT decoded,
    output int        passCount,
    output int        failCount,
    output int        errCount
);

    int              fd;
    logic            prevReq;
    logic            prevAck;
    logic            resetSeen;
    logic            found;
    logic [8*20-1:0] testName;
    decodeOutT       expOut;
    decodeOutT       heldOut;
    decodeOutT       nopOut;

    // Next data line of the golden file, notes skipped
    task automatic readGolden(output logic ok, output logic [8*20-1:0] name,
                              output decodeOutT exp);
        string                   line;
        int                      n;
        logic [`XLEN-1:0]        word;
        logic [`XLEN-1:0]        imm;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`REG_ADDR_W-1:0]  rs1;
        logic [`REG_ADDR_W-1:0]  rs2;
        logic [2:0]              func3;
        logic [$bits(ctrlT)-1:0] ctrlBits;
        ok = 1'b0;
        while (!ok && fd != 0 && !$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h", name, word, imm,
                            rd, rs1, rs2, func3, ctrlBits);
                // Same field order as the packed output
                exp = {rd, rs1, rs2, func3, imm, ctrlBits};
                ok  = (n == 8);
            end
        end
    endtask

    initial
    begin
        passCount = 0;
        failCount = 0;
        errCount  = 0;
        prevReq   = 1'b0;
        prevAck   = 1'b0;
        resetSeen = 1'b0;
        // NOP is ADD on registers with nothing written
        nopOut              = '0;
        nopOut.ctrl.aluSrc  = 1'b1;
        nopOut.ctrl.aluOp   = AOP_ARITH;
        nopOut.ctrl.aluCtrl = ALU_ADD;
        fd = $fopen("verif/decode_golden.txt", "r");
        if (fd == 0)
        begin
            $display("Checker cannot open verif/decode_golden.txt");
            errCount++;
        end
        forever
        begin
            // Mid-cycle, all signals settled
            @(negedge clk);
            if (rst)
            begin
                prevReq = 1'b0;
                prevAck = 1'b0;
            end
            else
            begin
                // First look after reset, before any request
                if (!resetSeen)
                begin
                    resetSeen = 1'b1;
                    if (ack)
                    begin
                        $display("ack is high right after reset");
                        errCount++;
                    end
                    if (decoded !== nopOut)
                    begin
                        $display("CHECK FAILED reset_nop expected %h actual %h",
                                 nopOut, decoded);
                        failCount++;
                    end
                    else
                    begin
                        $display("PASS reset_nop %h", decoded);
                        passCount++;
                    end
                end
                // Four-phase rules
                if (ack && !prevAck && !prevReq)
                begin
                    $display("ack rose although req was low");
                    errCount++;
                end
                if (prevReq && !prevAck && !ack)
                begin
                    $display("ack did not rise one edge after req");
                    errCount++;
                end
                if (prevAck && !prevReq && ack)
                begin
                    $display("ack stayed high after req fell");
                    errCount++;
                end
                if (prevAck && prevReq && !ack)
                begin
                    $display("ack fell while req was still high");
                    errCount++;
                end
                if (ack && !prevAck)
                begin
                    readGolden(found, testName, expOut);
                    if (!found)
                    begin
                        $display("ack rose but no golden line is left");
                        errCount++;
                    end
                    else if (decoded !== expOut)
                    begin
                        $display("CHECK FAILED %0s expected %h actual %h",
                                 testName, expOut, decoded);
                        failCount++;
                    end
                    else
                    begin
                        $display("PASS %0s %h", testName, decoded);
                        passCount++;
                    end
                    heldOut = decoded;
                end
                else if (ack && prevAck && decoded !== heldOut)
                begin
                    $display("decoded output changed while ack was held high");
                    errCount++;
                end
                prevReq = req;
                prevAck = ack;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/decodeTb.sv
// Decode stage testbench
`default_nettype none

`include "rv32Decode_settings.svh"

module decodeTb
    import decodePkg::*;
();

    localparam int HALF_PERIOD = 10;
    localparam int DRIVE_DELAY = 2;

    logic             clk = 1'b0;
    logic             rst;
    logic             req;
    logic [`XLEN-1:0] instr;
    logic             ack;
    decodeOutT        decoded;

    // Instruction words in golden file order
    logic [`XLEN-1:0] words[$];
    int               limit;
    int               cycles = 0;
    int               passCount;
    int               failCount;
    int               errCount;

    decodeStage DUT
    (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .instr   (instr),
        .ack     (ack),
        .decoded (decoded)
    );

    decodeChecker uCheck
    (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .ack       (ack),
        .decoded   (decoded),
        .passCount (passCount),
        .failCount (failCount),
        .errCount  (errCount)
    );

    always #HALF_PERIOD clk = ~clk;

    // Hard stop if a handshake never completes
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit)
        begin
            $display("Timeout after %0d cycles, handshake did not complete", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // Only the word column is needed for driving
    task automatic loadWords();
        int               fd;
        int               n;
        string            line;
        logic [8*20-1:0]  name;
        logic [`XLEN-1:0] word;
        fd = $fopen("verif/decode_golden.txt", "r");
        if (fd == 0)
            return;
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%s %h", name, word);
                if (n == 2)
                    words.push_back(word);
            end
        end
        $fclose(fd);
    endtask

    // Inputs change just after the edge
    task automatic stepCycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic waitAck(input logic level);
        do
            stepCycle();
        while (ack != level);
    endtask

    initial
    begin
        int hold;
        int idle;
        int tbErrors;
        void'($urandom(32'h0e25_2f39));
        rst      = 1'b1;
        req      = 1'b0;
        instr    = '0;
        tbErrors = 0;
        loadWords();
        // Worst case per test is about 8 cycles
        limit = words.size() * 10 + 20;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        stepCycle();
        foreach (words[i])
        begin
            instr = words[i];
            req   = 1'b1;
            waitAck(1'b1);
            // Keep req up a few cycles, ack must hold
            hold = $urandom_range(3, 0);
            repeat (hold) stepCycle();
            req = 1'b0;
            waitAck(1'b0);
            idle = $urandom_range(3, 0);
            repeat (idle) stepCycle();
        end
        repeat (2) stepCycle();
        if (words.size() == 0)
        begin
            $display("No stimulus lines read from verif/decode_golden.txt");
            tbErrors++;
        end
        // One result per golden line plus the reset check
        if (passCount + failCount != words.size() + 1)
        begin
            $display("Checker reported %0d results where %0d were due",
                     passCount + failCount, words.size() + 1);
            tbErrors++;
        end
        $display("Tests passed %0d, failed %0d, other errors %0d",
                 passCount, failCount, errCount + tbErrors);
        if (failCount == 0 && errCount == 0 && tbErrors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/decode_golden.txt
# Columns are name, instruction, immediate, rd, rs1, rs2, func3 and packed controls, all hex
# Control bits from msb are memWrite memRead regWrite aluSrc aluOp aluCtrl branch memToReg
op_add 003100B3 00000000 01 02 03 0 0908
op_sub 403100B3 00000000 01 02 03 0 0910
op_sll 003110B3 00000000 01 02 03 1 0918
op_slt 003120B3 00000000 01 02 03 2 0924
op_sltu 003130B3 00000000 01 02 03 3 0928
op_xor 003140B3 00000000 01 02 03 4 090C
op_srl 003150B3 00000000 01 02 03 5 091C
op_sra 403150B3 00000000 01 02 03 5 0920
op_or 003160B3 00000000 01 02 03 6 0904
op_and 003170B3 00000000 01 02 03 7 0900
md_mul 027302B3 00000000 05 06 07 0 092C
md_mulh 027312B3 00000000 05 06 07 1 0930
md_mulhsu 027322B3 00000000 05 06 07 2 0934
md_mulhu 027332B3 00000000 05 06 07 3 0938
md_div 027342B3 00000000 05 06 07 4 093C
md_divu 027352B3 00000000 05 06 07 5 0940
md_rem 027362B3 00000000 05 06 07 6 0944
md_remu 027372B3 00000000 05 06 07 7 0948
opimm_addi_b30 40058513 00000400 0a 0b 00 0 0D08
opimm_slli 00559513 00000005 0a 0b 05 1 0D18
opimm_slti_neg FF85A513 FFFFFFF8 0a 0b 18 2 0D24
opimm_sltiu 7FF5B513 000007FF 0a 0b 1f 3 0D28
opimm_xori_neg FFF5C513 FFFFFFFF 0a 0b 1f 4 0D0C
opimm_srli 0035D513 00000003 0a 0b 03 5 0D1C
opimm_srai 4035D513 00000403 0a 0b 03 5 0D20
opimm_ori 0F05E513 000000F0 0a 0b 10 6 0D04
opimm_andi_neg 8005F513 FFFFF800 0a 0b 00 7 0D00
load_lw_neg FFC42203 FFFFFFFC 04 08 1c 2 1C09
store_sw_neg FE912A23 FFFFFFF4 14 02 09 2 2408
store_sb 06530223 00000064 04 06 05 0 2408
branch_beq_neg FE208CE3 FFFFFFF8 19 01 02 0 0092
branch_bne_pos 00419863 00000010 10 03 04 1 0092
branch_blt_b11 0020C0E3 00000800 01 01 02 4 0092
lui_pos 123453B7 12345000 07 08 03 5 0E08
lui_neg FFFFF3B7 FFFFF000 07 1f 1f 7 0E08
auipc_msb 80000197 80000000 03 00 00 0 0E88
jal_pos 001000EF 00000800 01 00 01 0 0D8A
jal_neg FFDFF06F FFFFFFFC 00 1f 1d 7 0D8A
jalr_neg FF0280E7 FFFFFFF0 01 05 10 0 0F8A
nop_zero 00000000 00000000 00 00 00 0 0508
nop_ecall 00000073 00000000 00 00 00 0 0508
nop_all_ones FFFFFFFF 00000000 1f 1f 1f 7 0508

//--- compile.f
+incdir+hw
hw/decodePkg.sv
hw/instrLatch.sv
hw/immGen.sv
hw/aluCtrlDecode.sv
hw/ctrlDecode.sv
hw/decodeStage.sv
verif/decodeChecker.sv
verif/decodeTb.sv

//--- run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
verilator --binary --assert -f compile.f --top-module decodeTb -o decodeSim > build.log 2>&1 \
    && ./obj_dir/decodeSim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Verification passed" sim.log && exit 0 || exit 1
